/* pwr_seq_defines.svh */
// ---------------------------------------
// Power sequencer constants
// Rail count, timing limits, register map
// and identification values
// ---------------------------------------
`ifndef PWR_SEQ_DEFINES_SVH
`define PWR_SEQ_DEFINES_SVH

// Rail 0 is the ATX supply
`define RAIL_COUNT            9

// Timing in clock cycles
`define RAIL_DELAY_CYCLES     16
`define PG_TIMEOUT_CYCLES     200
`define ATX_PG_TIMEOUT_CYCLES 400

// Identification
`define SEQ_VERSION           8'h01
`define SEQ_VENDOR_ID         32'h5057_5351

// Register byte offsets
`define REG_ID                8'h00
`define REG_STATUS            8'h04
`define REG_EN                8'h08
`define REG_PG                8'h0C
`define REG_FAIL              8'h10
`define REG_CTRL              8'h14
`define REG_CLEAR             8'h18
`define REG_VENDOR            8'h1C

`endif

/* pwr_seq_pkg.sv */
// ---------------------------------------
// Power sequencer types
// Rail vectors, fault record, host control
// and AXI4-Lite channel bundles
// ---------------------------------------
`default_nettype none
`include "pwr_seq_defines.svh"

package pwr_seq_pkg;

	// One bit per sequenced rail
	typedef logic [`RAIL_COUNT-1:0] rail_vec_t;

	typedef struct packed {
		rail_vec_t en;
		rail_vec_t pg;
		rail_vec_t done;
	} rail_state_t;

	typedef struct packed {
		logic      wait_err;
		logic      operation_err;
		logic      err_found;
		rail_vec_t fail_detail;
	} fault_t;

	typedef struct packed {
		logic force_enable;
		// Single-cycle pulse
		logic clear_err;
	} seq_ctrl_t;

	typedef struct packed {
		logic        awvalid;
		logic [7:0]  awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic        bready;
		logic        arvalid;
		logic [7:0]  araddr;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

	typedef enum logic [1:0] {
		AXIL_IDLE,
		AXIL_WRESP,
		AXIL_RDATA
	} axil_state_e;

	typedef enum logic [7:0] {
		SEL_ID     = `REG_ID,
		SEL_STATUS = `REG_STATUS,
		SEL_EN     = `REG_EN,
		SEL_PG     = `REG_PG,
		SEL_FAIL   = `REG_FAIL,
		SEL_CTRL   = `REG_CTRL,
		SEL_CLEAR  = `REG_CLEAR,
		SEL_VENDOR = `REG_VENDOR
	} reg_sel_e;

endpackage

`default_nettype wire

/* pg_sync_stage.sv */
// ---------------------------------------
// Input synchroniser stage
// Power-good and system enable into the
// clock domain, sysen falling-edge pulse
// ---------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pg_sync_stage (
	input  wire logic                   clk_in,
	input  wire logic                   rst_n,
	input  wire pwr_seq_pkg::rail_vec_t pg_raw,
	input  wire logic                   sysen,
	input  wire logic                   force_enable,
	output pwr_seq_pkg::rail_vec_t      pg_sync,
	output logic                        sysen_sync,
	output logic                        host_clear
);
	import pwr_seq_pkg::*;

	rail_vec_t pg_meta;
	logic      sysen_meta;

	// Two-flop synchroniser for the power-good pins
	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			pg_meta <= '0;
			pg_sync <= '0;
		end else begin
			pg_meta <= pg_raw;
			pg_sync <= pg_meta;
		end
	end

	// Host force enable works the same as the sysen pin
	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			sysen_meta <= 1'b0;
			sysen_sync <= 1'b0;
			host_clear <= 1'b0;
		end else begin
			sysen_meta <= sysen | force_enable;
			sysen_sync <= sysen_meta;
			// High in the same cycle that sysen_sync drops
			host_clear <= sysen_sync & ~sysen_meta;
		end
	end

endmodule

`default_nettype wire

/* rail_sequencer.sv */
// ---------------------------------------
// Rail sequencer
// Enables rails bottom-up with a settling
// delay, drops them top-down, and reports
// system good
// ---------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "pwr_seq_defines.svh"

module rail_sequencer (
	input  wire logic                   clk_in,
	input  wire logic                   rst_n,
	input  wire pwr_seq_pkg::rail_vec_t pg_sync,
	input  wire logic                   sysen_sync,
	input  wire pwr_seq_pkg::fault_t    fault,
	output pwr_seq_pkg::rail_state_t    rail,
	output logic                        sysgood
);
	import pwr_seq_pkg::*;

	localparam int TOP = `RAIL_COUNT - 1;
	localparam int CNT_W = $clog2(`RAIL_DELAY_CYCLES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`RAIL_DELAY_CYCLES - 1);

	rail_vec_t        en_q;
	rail_vec_t        done_q;
	rail_vec_t        settle_req;
	rail_vec_t        settle_sel;
	rail_vec_t        en_up;
	rail_vec_t        en_down;
	logic [CNT_W-1:0] delay_cnt;

	// Rails that are up with power-good but still settling
	assign settle_req = en_q & pg_sync & ~done_q;
	// The lowest one owns the shared counter
	assign settle_sel = settle_req & (~settle_req + rail_vec_t'(1));

	// Rail 0 goes first, then each rail once the one below has settled
	assign en_up = {done_q[TOP-1:0], 1'b1};

	// Hold a rail while the rail above still reports power-good
	// Top rail has nothing above so it drops at once
	assign en_down = en_q & {1'b0, pg_sync[TOP:1]};

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			en_q      <= '0;
			done_q    <= '0;
			delay_cnt <= '0;
			sysgood   <= 1'b0;
		end else begin
			sysgood <= done_q[TOP];
			if (fault.err_found) begin
				// Hard shutdown of every rail
				en_q      <= '0;
				done_q    <= '0;
				delay_cnt <= '0;
			end else if (!sysen_sync) begin
				en_q      <= en_down;
				done_q    <= '0;
				delay_cnt <= '0;
			end else begin
				en_q <= en_up;
				if (settle_sel == '0) begin
					delay_cnt <= '0;
				end else if (delay_cnt == CNT_LAST) begin
					delay_cnt <= '0;
					done_q    <= done_q | settle_sel;
				end else begin
					delay_cnt <= delay_cnt + 1'b1;
				end
			end
		end
	end

	assign rail = '{en: en_q, pg: pg_sync, done: done_q};

	// While powered up, no rail may be on above one that has not settled
	a_en_order: assert property (
		@(posedge clk_in) disable iff (!rst_n)
		(sysen_sync && $past(sysen_sync)) |-> ((en_q[TOP:1] & ~done_q[TOP-1:0]) == '0)
	) else $error("Rail enabled before the rail below settled");

endmodule

`default_nettype wire

/* fault_monitor.sv */
// ---------------------------------------
// Fault monitor
// Power-good wait watchdog, power-loss
// detection, error latch and fail snapshot
// ---------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "pwr_seq_defines.svh"

module fault_monitor (
	input  wire logic                     clk_in,
	input  wire logic                     rst_n,
	input  wire pwr_seq_pkg::rail_state_t rail,
	input  wire logic                     clear_err,
	input  wire logic                     host_clear,
	output pwr_seq_pkg::fault_t           fault
);
	import pwr_seq_pkg::*;

	localparam int WAIT_W = $clog2(`ATX_PG_TIMEOUT_CYCLES + 2);
	localparam logic [WAIT_W-1:0] RAIL_LIMIT = WAIT_W'(`PG_TIMEOUT_CYCLES);
	localparam logic [WAIT_W-1:0] ATX_LIMIT = WAIT_W'(`ATX_PG_TIMEOUT_CYCLES);

	rail_vec_t         wait_req;
	rail_vec_t         wait_sel;
	rail_vec_t         pg_lost;
	rail_vec_t         fail_q;
	logic [WAIT_W-1:0] wait_cnt;
	logic [WAIT_W-1:0] wait_limit;
	logic              wait_over;
	logic              clear;
	logic              err_set;
	logic              wait_err_q;
	logic              operation_err_q;
	logic              err_found_q;

	assign clear = clear_err | host_clear;

	// Lowest rail that is enabled without power-good
	assign wait_req = rail.en & ~rail.pg;
	assign wait_sel = wait_req & (~wait_req + rail_vec_t'(1));
	// ATX supply gets a longer ramp
	assign wait_limit = wait_sel[0] ? ATX_LIMIT : RAIL_LIMIT;
	assign wait_over = (wait_sel != '0) && (wait_cnt > wait_limit);

	// Settled rail that lost power-good
	assign pg_lost = rail.done & ~rail.pg;

	assign err_set = (wait_err_q | operation_err_q) & ~err_found_q;

	// Counter stops one past the limit
	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			wait_cnt <= '0;
		end else if (clear || wait_sel == '0) begin
			wait_cnt <= '0;
		end else if (wait_cnt <= wait_limit) begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			wait_err_q      <= 1'b0;
			operation_err_q <= 1'b0;
			err_found_q     <= 1'b0;
			fail_q          <= '0;
		end else if (clear) begin
			wait_err_q      <= 1'b0;
			operation_err_q <= 1'b0;
			err_found_q     <= 1'b0;
			fail_q          <= '0;
		end else begin
			if (wait_over) begin
				wait_err_q <= 1'b1;
			end
			if (pg_lost != '0) begin
				operation_err_q <= 1'b1;
			end
			if (wait_err_q | operation_err_q) begin
				err_found_q <= 1'b1;
			end
			// Enables are still up here, so this marks the failing rails
			if (err_set) begin
				fail_q <= rail.en ^ rail.pg;
			end
		end
	end

	assign fault = '{
		wait_err:      wait_err_q,
		operation_err: operation_err_q,
		err_found:     err_found_q,
		fail_detail:   fail_q
	};

	a_fail_hold: assert property (
		@(posedge clk_in) disable iff (!rst_n)
		!$stable(fail_q) |-> ($rose(err_found_q) || $past(clear))
	) else $error("fail_detail changed outside an error capture or clear");

endmodule

`default_nettype wire

/* seq_regs_axil.sv */
// ---------------------------------------
// AXI4-Lite register slave
// Status, rail vectors, identification,
// force enable and error clear
// ---------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "pwr_seq_defines.svh"

module seq_regs_axil (
	input  wire logic                     clk_in,
	input  wire logic                     rst_n,
	input  wire pwr_seq_pkg::axil_req_t   axil_req,
	output pwr_seq_pkg::axil_rsp_t        axil_rsp,
	input  wire pwr_seq_pkg::rail_state_t rail,
	input  wire pwr_seq_pkg::fault_t      fault,
	input  wire logic                     sysgood,
	input  wire logic                     sysen_sync,
	output pwr_seq_pkg::seq_ctrl_t        ctrl
);
	import pwr_seq_pkg::*;

	axil_state_e state;
	logic        wr_take;
	logic        rd_take;
	logic        force_q;
	logic        clear_q;
	logic [31:0] rd_mux;
	logic [31:0] rdata_q;

	// Write needs address and data together and wins over a read
	assign wr_take = (state == AXIL_IDLE) && axil_req.awvalid && axil_req.wvalid;
	assign rd_take = (state == AXIL_IDLE) && axil_req.arvalid && !wr_take;

	// One transaction at a time
	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			state <= AXIL_IDLE;
		end else begin
			case (state)
				AXIL_IDLE: begin
					if (wr_take) begin
						state <= AXIL_WRESP;
					end else if (rd_take) begin
						state <= AXIL_RDATA;
					end
				end
				AXIL_WRESP: begin
					if (axil_req.bready) begin
						state <= AXIL_IDLE;
					end
				end
				AXIL_RDATA: begin
					if (axil_req.rready) begin
						state <= AXIL_IDLE;
					end
				end
				default: state <= AXIL_IDLE;
			endcase
		end
	end

	// Writes to read-only or unmapped offsets fall through
	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			force_q <= 1'b0;
			clear_q <= 1'b0;
		end else begin
			clear_q <= 1'b0;
			if (wr_take) begin
				case (reg_sel_e'(axil_req.awaddr))
					SEL_CTRL:  force_q <= axil_req.wdata[0];
					SEL_CLEAR: clear_q <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		case (reg_sel_e'(axil_req.araddr))
			SEL_ID:     rd_mux = 32'(`SEQ_VERSION);
			SEL_STATUS: rd_mux = {27'b0, fault.wait_err, fault.operation_err,
					fault.err_found, sysen_sync, sysgood};
			SEL_EN:     rd_mux = 32'(rail.en);
			SEL_PG:     rd_mux = 32'(rail.pg);
			SEL_FAIL:   rd_mux = 32'(fault.fail_detail);
			SEL_CTRL:   rd_mux = {31'b0, force_q};
			SEL_VENDOR: rd_mux = `SEQ_VENDOR_ID;
			default:    rd_mux = 32'b0;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (rd_take) begin
			rdata_q <= rd_mux;
		end
	end

	assign axil_rsp = '{
		awready: wr_take,
		wready:  wr_take,
		bvalid:  state == AXIL_WRESP,
		bresp:   AXIL_RESP_OKAY,
		arready: rd_take,
		rvalid:  state == AXIL_RDATA,
		rdata:   rdata_q,
		rresp:   AXIL_RESP_OKAY
	};

	assign ctrl = '{force_enable: force_q, clear_err: clear_q};

	a_bvalid_hold: assert property (
		@(posedge clk_in) disable iff (!rst_n)
		(axil_rsp.bvalid && !axil_req.bready) |=> axil_rsp.bvalid
	) else $error("bvalid dropped before bready");

endmodule

`default_nettype wire

/* pwr_seq_top.sv */
// ---------------------------------------
// Power sequencer top level
// Synchroniser, sequencer, fault monitor
// and host register slave
// ---------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pwr_seq_top (
	input  wire logic                   clk_in,
	input  wire logic                   rst_n,
	input  wire logic                   sysen,
	input  wire pwr_seq_pkg::rail_vec_t pg_raw,
	output pwr_seq_pkg::rail_vec_t      rail_en,
	output logic                        sysgood,
	input  wire pwr_seq_pkg::axil_req_t axil_req,
	output pwr_seq_pkg::axil_rsp_t      axil_rsp
);
	import pwr_seq_pkg::*;

	rail_vec_t   pg_sync;
	logic        sysen_sync;
	logic        host_clear;
	rail_state_t rail;
	fault_t      fault;
	seq_ctrl_t   ctrl;

	pg_sync_stage i_pg_sync_stage (
		.clk_in       (clk_in),
		.rst_n        (rst_n),
		.pg_raw       (pg_raw),
		.sysen        (sysen),
		.force_enable (ctrl.force_enable),
		.pg_sync      (pg_sync),
		.sysen_sync   (sysen_sync),
		.host_clear   (host_clear)
	);

	rail_sequencer i_rail_sequencer (
		.clk_in     (clk_in),
		.rst_n      (rst_n),
		.pg_sync    (pg_sync),
		.sysen_sync (sysen_sync),
		.fault      (fault),
		.rail       (rail),
		.sysgood    (sysgood)
	);

	// Fault flag loops back into the sequencer
	fault_monitor i_fault_monitor (
		.clk_in     (clk_in),
		.rst_n      (rst_n),
		.rail       (rail),
		.clear_err  (ctrl.clear_err),
		.host_clear (host_clear),
		.fault      (fault)
	);

	seq_regs_axil i_seq_regs_axil (
		.clk_in     (clk_in),
		.rst_n      (rst_n),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.rail       (rail),
		.fault      (fault),
		.sysgood    (sysgood),
		.sysen_sync (sysen_sync),
		.ctrl       (ctrl)
	);

	assign rail_en = rail.en;

endmodule

`default_nettype wire

/* tb_pwr_seq.sv */
// ----------------------------------------
// Power sequencer testbench
// Rail model, AXI4-Lite host tasks,
// reference results and self-checks
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "pwr_seq_defines.svh"

module tb_pwr_seq;
	import pwr_seq_pkg::*;

	localparam int PG_DELAY = 5;
	// Two sync stages, the settling delay and the enable register
	localparam int SETTLE_MIN = 2 + `RAIL_DELAY_CYCLES + 1;
	localparam int UP_CYCLES = `RAIL_COUNT * (PG_DELAY + SETTLE_MIN + 2);
	localparam int DOWN_CYCLES = `RAIL_COUNT * (PG_DELAY + 4);
	localparam int BUS_CYCLES = 32 * 10;
	localparam int CYCLE_LIMIT =
		2 * (4 * UP_CYCLES + 3 * DOWN_CYCLES + `ATX_PG_TIMEOUT_CYCLES + BUS_CYCLES);

	typedef enum int {SC_IDLE, SC_UP, SC_STUCK, SC_LOSS} scenario_e;

	typedef struct packed {
		logic [31:0] status;
		logic [31:0] en;
		logic [31:0] fail;
	} expect_t;

	logic        clk_in;
	logic        rst_n;
	logic        sysen;
	rail_vec_t   pg_raw;
	rail_vec_t   rail_en;
	logic        sysgood;
	axil_req_t   axil_req;
	axil_rsp_t   axil_rsp;
	rail_vec_t   en_prev;
	logic [31:0] lcg_state;
	logic [31:0] rd_data;
	int          cycle;
	int          errors;
	int          checks;
	int          stuck_rail;
	int          drop_rail;
	int          on_cnt [`RAIL_COUNT];
	int          off_cnt [`RAIL_COUNT];
	int          pg_rise_at [`RAIL_COUNT];
	int          rise_order [$];
	int          fall_order [$];

	pwr_seq_top i_pwr_seq_top (
		.clk_in   (clk_in),
		.rst_n    (rst_n),
		.sysen    (sysen),
		.pg_raw   (pg_raw),
		.rail_en  (rail_en),
		.sysgood  (sysgood),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp)
	);

	// Register contents each scenario should leave behind
	function automatic expect_t expected_regs(scenario_e sc, int bad_rail);
		expect_t r;
		r = '0;
		case (sc)
			SC_UP: begin
				// sysen_sync and sysgood
				r.status = 32'b00011;
				r.en = 32'((1 << `RAIL_COUNT) - 1);
			end
			SC_STUCK: begin
				// wait_err, err_found, sysen_sync
				r.status = 32'b10110;
				r.fail = 32'(1) << bad_rail;
			end
			SC_LOSS: begin
				// operation_err, err_found, sysen_sync
				r.status = 32'b01110;
				r.fail = 32'(1) << bad_rail;
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	// Rail expected at position pos of the enable or disable sequence
	function automatic int order_at(logic up, int pos);
		if (up) begin
			return pos;
		end
		return `RAIL_COUNT - 1 - pos;
	endfunction

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (expected === actual) else begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic stall_ready();
		lcg_state = lcg_next(lcg_state);
		repeat (lcg_state[17:16]) begin
			@(posedge clk_in);
			#1;
		end
	endtask

	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clk_in);
		#1;
		axil_req.awvalid = 1'b1;
		axil_req.awaddr = addr;
		axil_req.wvalid = 1'b1;
		axil_req.wdata = data;
		do begin
			@(negedge clk_in);
		end while (!(axil_rsp.awready && axil_rsp.wready));
		@(posedge clk_in);
		#1;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		stall_ready();
		axil_req.bready = 1'b1;
		do begin
			@(negedge clk_in);
		end while (!axil_rsp.bvalid);
		check_value("write response", 32'(AXIL_RESP_OKAY), 32'(axil_rsp.bresp));
		@(posedge clk_in);
		#1;
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
		@(posedge clk_in);
		#1;
		axil_req.arvalid = 1'b1;
		axil_req.araddr = addr;
		do begin
			@(negedge clk_in);
		end while (!axil_rsp.arready);
		@(posedge clk_in);
		#1;
		axil_req.arvalid = 1'b0;
		stall_ready();
		axil_req.rready = 1'b1;
		do begin
			@(negedge clk_in);
		end while (!axil_rsp.rvalid);
		data = axil_rsp.rdata;
		check_value("read response", 32'(AXIL_RESP_OKAY), 32'(axil_rsp.rresp));
		@(posedge clk_in);
		#1;
		axil_req.rready = 1'b0;
	endtask

	task automatic check_regs(input string name, input scenario_e sc, input int bad_rail);
		expect_t     want;
		logic [31:0] data;
		want = expected_regs(sc, bad_rail);
		axil_read(`REG_STATUS, data);
		check_value({name, " status"}, want.status, data);
		axil_read(`REG_EN, data);
		check_value({name, " enables"}, want.en, data);
		axil_read(`REG_FAIL, data);
		check_value({name, " fail"}, want.fail, data);
	endtask

	task automatic check_order(input string name, input logic up, input int count);
		int seen [$];
		if (up) begin
			seen = rise_order;
		end else begin
			seen = fall_order;
		end
		check_value({name, " length"}, 32'(count), 32'(seen.size()));
		for (int k = 0; k < count && k < seen.size(); k++) begin
			check_value(name, 32'(order_at(up, k)), 32'(seen[k]));
		end
	endtask

	task automatic drive_sysen(input logic level);
		@(posedge clk_in);
		#1;
		sysen = level;
	endtask

	task automatic wait_sysgood(input logic level);
		do begin
			@(negedge clk_in);
		end while (sysgood !== level);
		@(posedge clk_in);
		#1;
	endtask

	// Rails off and their power-good gone
	task automatic wait_all_off();
		do begin
			@(negedge clk_in);
		end while (rail_en !== '0 || pg_raw !== '0);
		@(posedge clk_in);
		#1;
	endtask

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;
	end

	always @(posedge clk_in) begin
		cycle++;
		if (cycle > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycle);
			$display("TEST FAIL");
			$finish;
		end
	end

	// Rail model where power-good follows the enable after a fixed ramp
	always @(posedge clk_in) begin
		#1;
		for (int i = 0; i < `RAIL_COUNT; i++) begin
			if (rail_en[i]) begin
				on_cnt[i] = on_cnt[i] + 1;
				off_cnt[i] = 0;
			end else begin
				off_cnt[i] = off_cnt[i] + 1;
				on_cnt[i] = 0;
			end
			if (i == drop_rail) begin
				pg_raw[i] = 1'b0;
			end else if (on_cnt[i] == PG_DELAY && i != stuck_rail) begin
				pg_raw[i] = 1'b1;
				pg_rise_at[i] = cycle;
			end else if (off_cnt[i] == PG_DELAY) begin
				pg_raw[i] = 1'b0;
			end
		end
	end

	// Records enable edges and checks that the rail below had settled
	always @(negedge clk_in) begin
		if (rst_n) begin
			for (int i = 0; i < `RAIL_COUNT; i++) begin
				if (rail_en[i] && !en_prev[i]) begin
					rise_order.push_back(i);
					if (i > 0) begin
						checks++;
						assert (pg_raw[i-1] && cycle - pg_rise_at[i-1] >= SETTLE_MIN) else begin
							errors++;
							$display("Rail %0d enabled before rail %0d settled", i, i - 1);
						end
					end
				end
				if (!rail_en[i] && en_prev[i]) begin
					fall_order.push_back(i);
				end
			end
		end
		en_prev = rail_en;
	end

	initial begin
		rst_n = 1'b0;
		sysen = 1'b0;
		pg_raw = '0;
		axil_req = '0;
		en_prev = '0;
		stuck_rail = -1;
		drop_rail = -1;
		lcg_state = 32'd2248;
		cycle = 0;
		errors = 0;
		checks = 0;
		repeat (3) @(posedge clk_in);
		#1;
		rst_n = 1'b1;

		check_value("reset enables", 32'h0, 32'(rail_en));
		check_value("reset sysgood", 32'h0, 32'(sysgood));
		axil_read(`REG_ID, rd_data);
		check_value("version", 32'(`SEQ_VERSION), rd_data);
		axil_read(`REG_VENDOR, rd_data);
		check_value("vendor id", `SEQ_VENDOR_ID, rd_data);
		check_regs("reset", SC_IDLE, 0);

		rise_order.delete();
		drive_sysen(1'b1);
		wait_sysgood(1'b1);
		check_regs("power-up", SC_UP, 0);
		check_order("power-up order", 1'b1, `RAIL_COUNT);

		fall_order.delete();
		drive_sysen(1'b0);
		wait_all_off();
		check_order("power-down order", 1'b0, `RAIL_COUNT);
		check_regs("power-down", SC_IDLE, 0);

		@(negedge clk_in);
		stuck_rail = 3;
		rise_order.delete();
		drive_sysen(1'b1);
		do begin
			@(negedge clk_in);
		end while (!rail_en[3]);
		wait_all_off();
		check_order("stuck rail order", 1'b1, 4);
		check_regs("stuck rail", SC_STUCK, 3);

		@(negedge clk_in);
		stuck_rail = -1;
		rise_order.delete();
		axil_write(`REG_CLEAR, 32'h1);
		wait_sysgood(1'b1);
		check_regs("clear and restart", SC_UP, 0);
		check_order("restart order", 1'b1, `RAIL_COUNT);

		@(negedge clk_in);
		drop_rail = 6;
		wait_all_off();
		check_value("power loss sysgood", 32'h0, 32'(sysgood));
		check_regs("power loss", SC_LOSS, 6);

		@(negedge clk_in);
		drop_rail = -1;
		drive_sysen(1'b0);
		// Sync stages, edge detect, then the clear lands
		repeat (4) @(posedge clk_in);
		check_regs("sysen fall clear", SC_IDLE, 0);

		rise_order.delete();
		axil_write(`REG_CTRL, 32'h1);
		wait_sysgood(1'b1);
		check_regs("force enable", SC_UP, 0);
		check_order("force enable order", 1'b1, `RAIL_COUNT);
		axil_read(`REG_CTRL, rd_data);
		check_value("force enable readback", 32'h1, rd_data);

		fall_order.delete();
		axil_write(`REG_CTRL, 32'h0);
		wait_all_off();
		check_order("force off order", 1'b0, `RAIL_COUNT);
		check_regs("force off", SC_IDLE, 0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
pwr_seq_pkg.sv
pg_sync_stage.sv
rail_sequencer.sv
fault_monitor.sv
seq_regs_axil.sv
pwr_seq_top.sv
tb_pwr_seq.sv

/* Makefile */
# Verilator build and run of the power sequencer testbench

SIM := obj_dir/Vtb_pwr_seq

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

$(SIM): sources.f pwr_seq_defines.svh $(shell grep -v '^+' sources.f)
	verilator --binary --timing -Wno-fatal --top-module tb_pwr_seq -f sources.f

clean:
	rm -rf obj_dir
